/* Bender.yml */
package:
  name: mmu

sources:
  - files:
      - hw/mmu_pkg.sv
      - hw/tlb_array.sv
      - hw/tlb_lookup.sv
      - hw/inst_translate.sv
      - hw/data_translate.sv
      - hw/mmu_top.sv
  - target: test
    files:
      - bench/mmu_properties.sv
      - bench/mmu_tb.sv

/* bench/mmu_patterns.txt */
# W index entry_hi entry_lo0 entry_lo1 page_mask | R index | P entry_hi exp_probe | C
# I asid pc exp_irom_pc exp_fault | D asid vaddr store hold exp_paddr flags(tlbl_d,tlbs,mod,refill)
W 00 00400001 0004001e 0004005a 00000000
W 05 10000022 0008d157 0008d195 00000000
W 0c 20002005 02af3787 0000043e 00000000
W 1f 7f000009 00000001 00000000 01ffe000
R 00
R 05
R 0c
R 1f
R 03
P 00400001 00000000
P 00400003 80000000
P 10000077 00000005
P 20002005 0000000c
P 20002006 80000000
P 00000000 00000001
I 01 00400123 01000123 0
I 01 00401abc 01001abc 0
I 33 10000010 02345010 0
I 05 20003004 00010004 0
I 00 9fc00000 9fc00000 0
I 02 00400010 00400010 1
C
I 00 10001000 10001000 1
C
I 01 00400123 01000123 0
D 01 00400040 0 0 01000040 0
D 01 00400080 1 3 01000080 0
D 44 10000abc 1 2 02345abc 0
D 00 80001234 0 1 80001234 0
D 01 00401000 0 0 01001000 0
D 07 00500000 0 0 00000000 9
C
D 44 10001008 1 0 00000000 4
C
D 01 00401010 1 0 00000000 2
C
D 09 20002000 1 0 00000000 5
C

/* bench/mmu_properties.sv */
`timescale 1ns/1ns

module mmu_properties (
    input logic            clk,
    input logic            resetn,
    input logic            exc_clear_i,
    input logic            mem_valid_i,
    input logic            data_ready_i,
    input logic            mem_ready_o,
    input logic            mem_valid_o,
    input mmu_pkg::vaddr_t mem_paddr_o,
    input logic            tlbl_d_o,
    input logic            tlbs_o,
    input logic            mod_o,
    input logic            refill_o
);

    // Output stage holds under back-pressure
    hold_until_ready: assert property (
        @(posedge clk) disable iff (!resetn)
        mem_valid_o && !data_ready_i |=> mem_valid_o && $stable(mem_paddr_o)
    ) else $error("mem_valid_o or mem_paddr_o changed while data_ready_i was low");

    // An accepted access never raises a cause
    no_ready_on_fault: assert property (
        @(posedge clk) disable iff (!resetn)
        mem_valid_i && mem_ready_o |=> !$rose(tlbl_d_o) && !$rose(tlbs_o) && !$rose(mod_o)
    ) else $error("mem_ready_o high during a faulting access");

    // Causes only drop after reset or an exception clear
    sticky_flags: assert property (
        @(posedge clk)
        ($fell(tlbl_d_o) || $fell(tlbs_o) || $fell(mod_o) || $fell(refill_o))
            |-> $past(!resetn || exc_clear_i)
    ) else $error("sticky cause flag fell without reset or exception clear");

endmodule

bind data_translate mmu_properties u_props (
    .clk          (clk),
    .resetn       (resetn),
    .exc_clear_i  (exc_clear_i),
    .mem_valid_i  (mem_valid_i),
    .data_ready_i (data_ready_i),
    .mem_ready_o  (mem_ready_o),
    .mem_valid_o  (mem_valid_o),
    .mem_paddr_o  (mem_paddr_o),
    .tlbl_d_o     (tlbl_d_o),
    .tlbs_o       (tlbs_o),
    .mod_o        (mod_o),
    .refill_o     (refill_o)
);

/* bench/mmu_tb.sv */
`timescale 1ns/1ns

module mmu_tb;

    import mmu_pkg::*;

    logic       clk;
    logic       resetn;
    logic       exc_clear_i;
    vaddr_t     pc_i;
    logic       pc_valid_i;
    logic       pc_ready_i;
    logic       pc_valid_o;
    logic       pc_ready_o;
    vaddr_t     irom_pc_o;
    vaddr_t     mem_vaddr_i;
    logic       mem_store_i;
    logic       mem_valid_i;
    logic       mem_ready_o;
    logic       mem_valid_o;
    vaddr_t     mem_paddr_o;
    logic       mem_store_o;
    logic       data_ready_i;
    word_t      entry_hi_i;
    word_t      entry_lo0_i;
    word_t      entry_lo1_i;
    word_t      page_mask_i;
    word_t      index_i;
    logic       tlbw_i;
    tlb_entry_t tlb_entry_o;
    word_t      probe_o;
    logic       tlbl_i_o;
    logic       tlbl_d_o;
    logic       tlbs_o;
    logic       mod_o;
    logic       refill_o;
    vaddr_t     badvaddr_o;

    // Reference copy of the TLB contents
    tlb_entry_t model [TLB_ENTRIES];
    int         errors;
    int         checks;

    mmu_top u_dut (
        .clk          (clk),
        .resetn       (resetn),
        .exc_clear_i  (exc_clear_i),
        .pc_i         (pc_i),
        .pc_valid_i   (pc_valid_i),
        .pc_ready_i   (pc_ready_i),
        .pc_valid_o   (pc_valid_o),
        .pc_ready_o   (pc_ready_o),
        .irom_pc_o    (irom_pc_o),
        .mem_vaddr_i  (mem_vaddr_i),
        .mem_store_i  (mem_store_i),
        .mem_valid_i  (mem_valid_i),
        .mem_ready_o  (mem_ready_o),
        .mem_valid_o  (mem_valid_o),
        .mem_paddr_o  (mem_paddr_o),
        .mem_store_o  (mem_store_o),
        .data_ready_i (data_ready_i),
        .entry_hi_i   (entry_hi_i),
        .entry_lo0_i  (entry_lo0_i),
        .entry_lo1_i  (entry_lo1_i),
        .page_mask_i  (page_mask_i),
        .index_i      (index_i),
        .tlbw_i       (tlbw_i),
        .tlb_entry_o  (tlb_entry_o),
        .probe_o      (probe_o),
        .tlbl_i_o     (tlbl_i_o),
        .tlbl_d_o     (tlbl_d_o),
        .tlbs_o       (tlbs_o),
        .mod_o        (mod_o),
        .refill_o     (refill_o),
        .badvaddr_o   (badvaddr_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_addr(input string name, input vaddr_t got, input vaddr_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_entry(input string name, input tlb_entry_t got,
                               input tlb_entry_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Command tasks
    //////////////////////////////////////////////////////////////////////

    // MIPS32 CP0 layout with PFN, C, D and V in EntryLo bits 25:1
    function automatic tlb_entry_t pack_entry(input word_t hi, input word_t lo0,
                                              input word_t lo1, input word_t mask);
        return {hi[31:13], hi[7:0], mask[24:13], lo0[0] & lo1[0], lo0[25:1], lo1[25:1]};
    endfunction

    task automatic next_cycle;
        @(posedge clk);
        #5;
    endtask

    task automatic write_entry(input word_t idx, input word_t hi, input word_t lo0,
                               input word_t lo1, input word_t mask);
        next_cycle();
        index_i     = idx;
        entry_hi_i  = hi;
        entry_lo0_i = lo0;
        entry_lo1_i = lo1;
        page_mask_i = mask;
        tlbw_i      = 1'b1;
        next_cycle();
        tlbw_i = 1'b0;
        model[idx[TLB_INDEX_W-1:0]] = pack_entry(hi, lo0, lo1, mask);
    endtask

    task automatic read_entry(input word_t idx);
        next_cycle();
        index_i = idx;
        @(negedge clk);
        check_entry("tlb_entry_o", tlb_entry_o, model[idx[TLB_INDEX_W-1:0]]);
    endtask

    task automatic probe_entry(input word_t hi, input word_t exp);
        next_cycle();
        entry_hi_i = hi;
        @(negedge clk);
        check_word("probe_o", probe_o, exp);
    endtask

    task automatic fetch_access(input word_t asid, input vaddr_t pc, input vaddr_t exp_pc,
                                input logic exp_fault);
        next_cycle();
        entry_hi_i = asid;
        pc_i       = pc;
        pc_valid_i = 1'b1;
        pc_ready_i = 1'b1;
        @(negedge clk);
        check_addr("irom_pc_o", irom_pc_o, exp_pc);
        check_flag("tlbl_i_o", tlbl_i_o, exp_fault);
        // Handshake blocked once the flag is held
        @(negedge clk);
        check_flag("pc_valid_o", pc_valid_o, !exp_fault);
        check_flag("pc_ready_o", pc_ready_o, !exp_fault);
        next_cycle();
        pc_valid_i = 1'b0;
        pc_ready_i = 1'b0;
        // Flag stays up with no fetch pending
        @(negedge clk);
        check_flag("tlbl_i_o", tlbl_i_o, exp_fault);
    endtask

    // Flag bits tlbl_d, tlbs, mod, refill from bit 3 down
    task automatic data_access(input word_t asid, input vaddr_t vaddr, input logic store,
                               input word_t hold, input vaddr_t exp_paddr,
                               input logic [3:0] flags);
        logic fault;
        int   waited;
        fault = (flags[3:1] != 3'b000);
        next_cycle();
        entry_hi_i   = asid;
        mem_vaddr_i  = vaddr;
        mem_store_i  = store;
        mem_valid_i  = 1'b1;
        data_ready_i = 1'b1;
        @(negedge clk);
        check_flag("mem_ready_o", mem_ready_o, !fault);
        next_cycle();
        mem_valid_i  = 1'b0;
        data_ready_i = (hold == 0);
        if (fault)
        begin
            data_ready_i = 1'b1;
            check_flag("mem_valid_o", mem_valid_o, 1'b0);
            check_flag("tlbl_d_o", tlbl_d_o, flags[3]);
            check_flag("tlbs_o", tlbs_o, flags[2]);
            check_flag("mod_o", mod_o, flags[1]);
            check_flag("refill_o", refill_o, flags[0]);
            check_addr("badvaddr_o", badvaddr_o, vaddr);
        end
        else
        begin
            waited = 0;
            while (mem_valid_o !== 1'b1 && waited < 50)
            begin
                @(negedge clk);
                waited++;
            end
            if (mem_valid_o !== 1'b1)
            begin
                errors++;
                $display("Timed out waiting for mem_valid_o on access to %h", vaddr);
            end
            else
            begin
                check_addr("mem_paddr_o", mem_paddr_o, exp_paddr);
                check_flag("mem_store_o", mem_store_o, store);
                for (int i = 0; i < hold; i++)
                begin
                    next_cycle();
                    check_flag("mem_valid_o", mem_valid_o, 1'b1);
                    check_addr("mem_paddr_o", mem_paddr_o, exp_paddr);
                end
                data_ready_i = 1'b1;
                next_cycle();
                check_flag("mem_valid_o", mem_valid_o, 1'b0);
            end
        end
    endtask

    task automatic clear_exceptions;
        next_cycle();
        exc_clear_i = 1'b1;
        next_cycle();
        exc_clear_i = 1'b0;
        check_flag("tlbl_i_o", tlbl_i_o, 1'b0);
        check_flag("tlbl_d_o", tlbl_d_o, 1'b0);
        check_flag("tlbs_o", tlbs_o, 1'b0);
        check_flag("mod_o", mod_o, 1'b0);
        check_flag("refill_o", refill_o, 1'b0);
        check_addr("badvaddr_o", badvaddr_o, 32'h0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Pattern reader
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int         fd;
        int         code;
        string      line;
        logic [7:0] cmd;
        word_t      a;
        word_t      b;
        word_t      c;
        word_t      d;
        word_t      e;
        word_t      f;
        errors       = 0;
        checks       = 0;
        resetn       = 1'b0;
        exc_clear_i  = 1'b0;
        pc_i         = '0;
        pc_valid_i   = 1'b0;
        pc_ready_i   = 1'b0;
        mem_vaddr_i  = '0;
        mem_store_i  = 1'b0;
        mem_valid_i  = 1'b0;
        data_ready_i = 1'b1;
        entry_hi_i   = '0;
        entry_lo0_i  = '0;
        entry_lo1_i  = '0;
        page_mask_i  = '0;
        index_i      = '0;
        tlbw_i       = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++)
            model[i] = '0;
        repeat (10) @(posedge clk);
        #5;
        resetn = 1'b1;
        fd = $fopen("bench/mmu_patterns.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("Could not open the pattern file bench/mmu_patterns.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                code = $fgets(line, fd);
                if (code == 0 || line.len() < 2 || line[0] == "#")
                    continue;
                code = $sscanf(line, "%c %h %h %h %h %h %h", cmd, a, b, c, d, e, f);
                case (cmd)
                    "W": write_entry(a, b, c, d, e);
                    "R": read_entry(a);
                    "P": probe_entry(a, b);
                    "I": fetch_access(a, b, c, d[0]);
                    "D": data_access(a, b, c[0], d, e, f[3:0]);
                    "C": clear_exceptions();
                    default:
                    begin
                        errors++;
                        $display("Unknown command in pattern line %s", line);
                    end
                endcase
            end
            $fclose(fd);
        end
        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* build.f */
hw/mmu_pkg.sv
hw/tlb_array.sv
hw/tlb_lookup.sv
hw/inst_translate.sv
hw/data_translate.sv
hw/mmu_top.sv
bench/mmu_properties.sv
bench/mmu_tb.sv

/* hw/data_translate.sv */
`timescale 1ns/1ns

module data_translate (
    input  logic            clk,
    input  logic            resetn,
    input  logic            exc_clear_i,
    input  mmu_pkg::vaddr_t mem_vaddr_i,
    input  logic            mem_store_i,
    input  logic            mem_valid_i,
    input  logic            data_ready_i,
    input  logic            hit_i,
    input  logic            valid_i,
    input  logic            dirty_i,
    input  mmu_pkg::pfn_t   pfn_i,
    output logic            mem_ready_o,
    output logic            mem_valid_o,
    output logic            mem_store_o,
    output mmu_pkg::vaddr_t mem_paddr_o,
    output logic            tlbl_d_o,
    output logic            tlbs_o,
    output logic            mod_o,
    output logic            refill_o,
    output mmu_pkg::vaddr_t badvaddr_o
);

    import mmu_pkg::*;

    logic   mapped_req;
    logic   miss_or_inv;
    logic   tlbl_d;
    logic   tlbs;
    logic   mod;
    logic   fault;
    logic   accept;
    vaddr_t paddr;

    //////////////////////////////////////////////////////////////////////
    // Fault detection
    //////////////////////////////////////////////////////////////////////

    assign mapped_req  = mem_valid_i && !mem_vaddr_i[31];
    assign miss_or_inv = !hit_i || !valid_i;

    assign tlbl_d = mapped_req && !mem_store_i && miss_or_inv;
    assign tlbs   = mapped_req && mem_store_i && miss_or_inv;
    // Store to a clean page
    assign mod    = mapped_req && mem_store_i && hit_i && valid_i && !dirty_i;
    assign fault  = tlbl_d || tlbs || mod;

    assign mem_ready_o = data_ready_i && !fault;
    assign accept      = mem_valid_i && mem_ready_o;

    assign paddr = mem_vaddr_i[31] ? mem_vaddr_i : {pfn_i, mem_vaddr_i[PAGE_OFFSET_W-1:0]};

    //////////////////////////////////////////////////////////////////////
    // Output stage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            mem_valid_o <= 1'b0;
            mem_paddr_o <= '0;
        end
        else if (accept)
        begin
            mem_valid_o <= 1'b1;
            mem_paddr_o <= paddr;
        end
        else if (data_ready_i)
            mem_valid_o <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            mem_store_o <= mem_store_i;
    end

    //////////////////////////////////////////////////////////////////////
    // Sticky causes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!resetn || exc_clear_i)
        begin
            tlbl_d_o   <= 1'b0;
            tlbs_o     <= 1'b0;
            mod_o      <= 1'b0;
            refill_o   <= 1'b0;
            badvaddr_o <= '0;
        end
        else
        begin
            if (tlbl_d)
                tlbl_d_o <= 1'b1;
            if (tlbs)
                tlbs_o <= 1'b1;
            if (mod)
                mod_o <= 1'b1;
            // Plain miss needs the refill vector
            if (mapped_req && !hit_i)
                refill_o <= 1'b1;
            if (fault)
                badvaddr_o <= mem_vaddr_i;
        end
    end

endmodule

/* hw/inst_translate.sv */
`timescale 1ns/1ns

module inst_translate (
    input  logic            clk,
    input  logic            resetn,
    input  logic            exc_clear_i,
    input  mmu_pkg::vaddr_t pc_i,
    input  logic            pc_valid_i,
    input  logic            pc_ready_i,
    input  logic            hit_i,
    input  logic            valid_i,
    input  mmu_pkg::pfn_t   pfn_i,
    output mmu_pkg::vaddr_t irom_pc_o,
    output logic            pc_valid_o,
    output logic            pc_ready_o,
    output logic            tlbl_i_o
);

    import mmu_pkg::*;

    logic mapped;
    logic fault;
    logic tlbl_q;

    assign mapped = !pc_i[31];

    // Fetch fault only counts on a real handshake
    assign fault = pc_valid_i && pc_ready_i && mapped && (!hit_i || !valid_i);

    always_ff @(posedge clk)
    begin
        if (!resetn || exc_clear_i)
            tlbl_q <= 1'b0;
        else if (fault)
            tlbl_q <= 1'b1;
    end

    assign tlbl_i_o = fault || tlbl_q;

    // Handshake blocked while the fault is pending
    assign pc_valid_o = pc_valid_i && !tlbl_q;
    assign pc_ready_o = pc_ready_i && !tlbl_q;

    always_comb
    begin
        if (mapped && hit_i && valid_i)
            irom_pc_o = {pfn_i, pc_i[PAGE_OFFSET_W-1:0]};
        else
            irom_pc_o = pc_i;
    end

endmodule

/* hw/mmu_pkg.sv */
package mmu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////////

    localparam int TLB_ENTRIES   = 32;
    localparam int TLB_INDEX_W   = 5;
    localparam int VPN2_W        = 19;
    localparam int ASID_W        = 8;
    localparam int MASK_W        = 12;
    localparam int PFN_W         = 20;
    localparam int PAGE_OFFSET_W = 12;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0]            vaddr_t;
    typedef logic [31:0]            word_t;
    typedef logic [TLB_INDEX_W-1:0] tlb_index_t;
    typedef logic [PFN_W-1:0]       pfn_t;

    // Half 0 from EntryLo0, half 1 from EntryLo1
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic [MASK_W-1:0] page_mask;
        logic              g;
        pfn_t              pfn0;
        logic [2:0]        c0;
        logic              d0;
        logic              v0;
        pfn_t              pfn1;
        logic [2:0]        c1;
        logic              d1;
        logic              v1;
    } tlb_entry_t;

    typedef tlb_entry_t tlb_array_t [TLB_ENTRIES];

endpackage

/* hw/mmu_top.sv */
`timescale 1ns/1ns

module mmu_top (
    input  logic                clk,
    input  logic                resetn,
    input  logic                exc_clear_i,
    // Fetch side
    input  mmu_pkg::vaddr_t     pc_i,
    input  logic                pc_valid_i,
    input  logic                pc_ready_i,
    output logic                pc_valid_o,
    output logic                pc_ready_o,
    output mmu_pkg::vaddr_t     irom_pc_o,
    // Data side
    input  mmu_pkg::vaddr_t     mem_vaddr_i,
    input  logic                mem_store_i,
    input  logic                mem_valid_i,
    output logic                mem_ready_o,
    output logic                mem_valid_o,
    output mmu_pkg::vaddr_t     mem_paddr_o,
    output logic                mem_store_o,
    input  logic                data_ready_i,
    // CP0 side
    input  mmu_pkg::word_t      entry_hi_i,
    input  mmu_pkg::word_t      entry_lo0_i,
    input  mmu_pkg::word_t      entry_lo1_i,
    input  mmu_pkg::word_t      page_mask_i,
    input  mmu_pkg::word_t      index_i,
    input  logic                tlbw_i,
    output mmu_pkg::tlb_entry_t tlb_entry_o,
    output mmu_pkg::word_t      probe_o,
    // Exceptions
    output logic                tlbl_i_o,
    output logic                tlbl_d_o,
    output logic                tlbs_o,
    output logic                mod_o,
    output logic                refill_o,
    output mmu_pkg::vaddr_t     badvaddr_o
);

    import mmu_pkg::*;

    tlb_array_t  entries;
    logic        inst_hit;
    logic        inst_valid;
    pfn_t        inst_pfn;
    logic        data_hit;
    logic        data_valid;
    logic        data_dirty;
    pfn_t        data_pfn;
    logic        probe_hit;
    tlb_index_t  probe_index;

    tlb_array u_array (
        .clk         (clk),
        .resetn      (resetn),
        .tlbw_i      (tlbw_i),
        .index_i     (index_i[TLB_INDEX_W-1:0]),
        .entry_hi_i  (entry_hi_i),
        .entry_lo0_i (entry_lo0_i),
        .entry_lo1_i (entry_lo1_i),
        .page_mask_i (page_mask_i),
        .entries_o   (entries),
        .entry_o     (tlb_entry_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Lookups
    //////////////////////////////////////////////////////////////////////

    tlb_lookup u_inst_lookup (
        .entries_i (entries),
        .vaddr_i   (pc_i),
        .asid_i    (entry_hi_i[ASID_W-1:0]),
        .hit_o     (inst_hit),
        .valid_o   (inst_valid),
        .dirty_o   (),
        .index_o   (),
        .pfn_o     (inst_pfn)
    );

    tlb_lookup u_data_lookup (
        .entries_i (entries),
        .vaddr_i   (mem_vaddr_i),
        .asid_i    (entry_hi_i[ASID_W-1:0]),
        .hit_o     (data_hit),
        .valid_o   (data_valid),
        .dirty_o   (data_dirty),
        .index_o   (),
        .pfn_o     (data_pfn)
    );

    // tlbp looks up EntryHi itself
    tlb_lookup u_probe_lookup (
        .entries_i (entries),
        .vaddr_i   (entry_hi_i),
        .asid_i    (entry_hi_i[ASID_W-1:0]),
        .hit_o     (probe_hit),
        .valid_o   (),
        .dirty_o   (),
        .index_o   (probe_index),
        .pfn_o     ()
    );

    assign probe_o = {!probe_hit, {(32 - 1 - TLB_INDEX_W){1'b0}}, probe_index};

    //////////////////////////////////////////////////////////////////////
    // Translators
    //////////////////////////////////////////////////////////////////////

    inst_translate u_inst (
        .clk         (clk),
        .resetn      (resetn),
        .exc_clear_i (exc_clear_i),
        .pc_i        (pc_i),
        .pc_valid_i  (pc_valid_i),
        .pc_ready_i  (pc_ready_i),
        .hit_i       (inst_hit),
        .valid_i     (inst_valid),
        .pfn_i       (inst_pfn),
        .irom_pc_o   (irom_pc_o),
        .pc_valid_o  (pc_valid_o),
        .pc_ready_o  (pc_ready_o),
        .tlbl_i_o    (tlbl_i_o)
    );

    data_translate u_data (
        .clk          (clk),
        .resetn       (resetn),
        .exc_clear_i  (exc_clear_i),
        .mem_vaddr_i  (mem_vaddr_i),
        .mem_store_i  (mem_store_i),
        .mem_valid_i  (mem_valid_i),
        .data_ready_i (data_ready_i),
        .hit_i        (data_hit),
        .valid_i      (data_valid),
        .dirty_i      (data_dirty),
        .pfn_i        (data_pfn),
        .mem_ready_o  (mem_ready_o),
        .mem_valid_o  (mem_valid_o),
        .mem_store_o  (mem_store_o),
        .mem_paddr_o  (mem_paddr_o),
        .tlbl_d_o     (tlbl_d_o),
        .tlbs_o       (tlbs_o),
        .mod_o        (mod_o),
        .refill_o     (refill_o),
        .badvaddr_o   (badvaddr_o)
    );

endmodule

/* hw/tlb_array.sv */
`timescale 1ns/1ns

module tlb_array (
    input  logic                clk,
    input  logic                resetn,
    input  logic                tlbw_i,
    input  mmu_pkg::tlb_index_t index_i,
    input  mmu_pkg::word_t      entry_hi_i,
    input  mmu_pkg::word_t      entry_lo0_i,
    input  mmu_pkg::word_t      entry_lo1_i,
    input  mmu_pkg::word_t      page_mask_i,
    output mmu_pkg::tlb_array_t entries_o,
    output mmu_pkg::tlb_entry_t entry_o
);

    import mmu_pkg::*;

    tlb_array_t tlb_q;
    tlb_entry_t new_entry;

    // Pack CP0 register fields into one entry
    always_comb
    begin
        new_entry.vpn2      = entry_hi_i[31:13];
        new_entry.asid      = entry_hi_i[ASID_W-1:0];
        new_entry.page_mask = page_mask_i[24:13];
        new_entry.g         = entry_lo0_i[0] & entry_lo1_i[0];
        new_entry.pfn0      = entry_lo0_i[25:6];
        new_entry.c0        = entry_lo0_i[5:3];
        new_entry.d0        = entry_lo0_i[2];
        new_entry.v0        = entry_lo0_i[1];
        new_entry.pfn1      = entry_lo1_i[25:6];
        new_entry.c1        = entry_lo1_i[5:3];
        new_entry.d1        = entry_lo1_i[2];
        new_entry.v1        = entry_lo1_i[1];
    end

    for (genvar i = 0; i < TLB_ENTRIES; i++)
    begin : g_entry
        always_ff @(posedge clk)
        begin
            if (!resetn)
                tlb_q[i] <= '0;
            else if (tlbw_i && index_i == TLB_INDEX_W'(i))
                tlb_q[i] <= new_entry;
        end
    end

    assign entries_o = tlb_q;

    // Indexed read for tlbr
    assign entry_o = tlb_q[index_i];

endmodule

/* hw/tlb_lookup.sv */
`timescale 1ns/1ns

module tlb_lookup (
    input  mmu_pkg::tlb_array_t         entries_i,
    input  mmu_pkg::vaddr_t             vaddr_i,
    input  logic [mmu_pkg::ASID_W-1:0]  asid_i,
    output logic                        hit_o,
    output logic                        valid_o,
    output logic                        dirty_o,
    output mmu_pkg::tlb_index_t         index_o,
    output mmu_pkg::pfn_t               pfn_o
);

    import mmu_pkg::*;

    logic [TLB_ENTRIES-1:0] match;
    logic [VPN2_W-1:0]      vpn2;
    tlb_entry_t             sel;
    logic                   odd;

    assign vpn2 = vaddr_i[31:PAGE_OFFSET_W+1];
    assign odd  = vaddr_i[PAGE_OFFSET_W];

    //////////////////////////////////////////////////////////////////////
    // Per-entry compare
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < TLB_ENTRIES; i++)
    begin : g_match
        logic [VPN2_W-1:0] care;
        logic              vpn_eq;
        logic              asid_eq;

        // Page mask bits are don't-care in the compare
        assign care    = ~VPN2_W'(entries_i[i].page_mask);
        assign vpn_eq  = ((entries_i[i].vpn2 ^ vpn2) & care) == '0;
        assign asid_eq = entries_i[i].g || (entries_i[i].asid == asid_i);
        assign match[i] = vpn_eq && asid_eq;
    end

    //////////////////////////////////////////////////////////////////////
    // Lowest matching index wins
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        hit_o   = 1'b0;
        index_o = '0;
        sel     = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--)
        begin
            if (match[i])
            begin
                hit_o   = 1'b1;
                index_o = TLB_INDEX_W'(i);
                sel     = entries_i[i];
            end
        end
    end

    // Even or odd page of the pair
    assign pfn_o   = odd ? sel.pfn1 : sel.pfn0;
    assign valid_o = odd ? sel.v1 : sel.v0;
    assign dirty_o = odd ? sel.d1 : sel.d0;

endmodule
